// ==== list.f ====
logic/filter_cond_pkg.sv
logic/sync_fifo.sv
logic/filter_cond_config.sv
logic/filter_cond_generator.sv
logic/engine_filter_cond.sv
sim/filter_cond_properties.sv
sim/tb_engine_filter_cond.sv

// ==== logic/engine_filter_cond.sv ====
/*
 * Filter-condition engine top level
 * Registers all ports, queues response packets in an input FIFO, filters
 * them in the generator against the permanent configuration and drains
 * passing packets through an output FIFO onto the request port.
 */

`timescale 1ns/1ps

module engine_filter_cond
    import filter_cond_pkg::*;
#(
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  pkt_t        response_i,
    output logic        response_ready_o,
    input  cfg_pkt_t    config_i,
    input  descriptor_t descriptor_i,
    output pkt_t        request_o,
    input  logic        request_ready_i,
    output logic        done_o
);

    localparam int PAYLOAD_W = ID_W + DATA_W;

    logic        areset_local;
    pkt_t        response_reg;
    cfg_pkt_t    config_reg;
    descriptor_t descriptor_reg;
    logic        request_ready_reg;

    // Input FIFO side
    logic                 in_empty;
    logic                 in_prog_full;
    logic                 in_valid;
    logic [PAYLOAD_W-1:0] in_dout;
    pkt_t                 fifo_pkt;

    // Output FIFO side
    logic                 out_empty;
    logic                 out_prog_full;
    logic                 out_pop;
    logic                 out_valid;
    logic [PAYLOAD_W-1:0] out_dout;
    pkt_t                 request_int;

    // Configuration and generator
    filter_cfg_t cfg;
    logic        cfg_loaded;
    logic        cfg_lock;
    logic        gen_pop;
    pkt_t        gen_pkt;
    logic        gen_done;

    // ----------------------------------------
    // Local reset and input registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        areset_local <= areset_csr_engine;
    end

    always_ff @(posedge ap_clk) begin
        response_reg.id        <= response_i.id;
        response_reg.data      <= response_i.data;
        config_reg.field       <= config_i.field;
        config_reg.word        <= config_i.word;
        descriptor_reg.run_tag <= descriptor_i.run_tag;
        if (areset_local) begin
            response_reg.valid   <= 1'b0;
            config_reg.valid     <= 1'b0;
            descriptor_reg.valid <= 1'b0;
            request_ready_reg    <= 1'b0;
        end else begin
            response_reg.valid   <= response_i.valid;
            config_reg.valid     <= config_i.valid;
            descriptor_reg.valid <= descriptor_i.valid;
            request_ready_reg    <= request_ready_i;
        end
    end

    // ----------------------------------------
    // Output registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        request_o.id   <= request_int.id;
        request_o.data <= request_int.data;
        if (areset_local) begin
            request_o.valid  <= 1'b0;
            response_ready_o <= 1'b1;
            done_o           <= 1'b1;
        end else begin
            request_o.valid  <= request_int.valid;
            response_ready_o <= !in_prog_full;
            done_o           <= gen_done;
        end
    end

    // ----------------------------------------
    // Response FIFO
    // ----------------------------------------
    sync_fifo #(
        .DATA_W_P   (PAYLOAD_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_fifo_response (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_local),
        .push_i           (response_reg.valid),
        .din_i            ({response_reg.id, response_reg.data}),
        .pop_i            (gen_pop && !in_empty),
        .dout_o           (in_dout),
        .valid_o          (in_valid),
        .empty_o          (in_empty),
        .prog_full_o      (in_prog_full)
    );

    assign fifo_pkt = '{valid: in_valid, id: in_dout[PAYLOAD_W-1:DATA_W],
                        data: in_dout[DATA_W-1:0]};

    // ----------------------------------------
    // Configuration and generator
    // ----------------------------------------
    filter_cond_config u_config (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_local),
        .config_i         (config_reg),
        .cfg_lock_i       (cfg_lock),
        .cfg_o            (cfg),
        .cfg_loaded_o     (cfg_loaded)
    );

    filter_cond_generator u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_local),
        .descriptor_i     (descriptor_reg),
        .cfg_i            (cfg),
        .cfg_loaded_i     (cfg_loaded),
        .cfg_lock_o       (cfg_lock),
        .pop_o            (gen_pop),
        .pkt_i            (fifo_pkt),
        .out_full_i       (out_prog_full),
        .pkt_o            (gen_pkt),
        .done_o           (gen_done)
    );

    // ----------------------------------------
    // Request FIFO
    // ----------------------------------------
    assign out_pop = !out_empty && request_ready_reg;

    sync_fifo #(
        .DATA_W_P   (PAYLOAD_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_fifo_request (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_local),
        .push_i           (gen_pkt.valid),
        .din_i            ({gen_pkt.id, gen_pkt.data}),
        .pop_i            (out_pop),
        .dout_o           (out_dout),
        .valid_o          (out_valid),
        .empty_o          (out_empty),
        .prog_full_o      (out_prog_full)
    );

    assign request_int = '{valid: out_valid, id: out_dout[PAYLOAD_W-1:DATA_W],
                           data: out_dout[DATA_W-1:0]};

endmodule : engine_filter_cond

// ==== logic/filter_cond_config.sv ====
/*
 * Filter-condition configuration block
 * Collects the opcode, compare value and packet count from configuration
 * packets. Fields persist across runs and writes are dropped while locked.
 */

`timescale 1ns/1ps

module filter_cond_config
    import filter_cond_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  cfg_pkt_t    config_i,
    input  logic        cfg_lock_i,
    output filter_cfg_t cfg_o,
    output logic        cfg_loaded_o
);

    // One loaded bit per field, ordered opcode, value, count
    logic [2:0]  loaded_q;
    filter_cfg_t cfg_q;
    logic        wr_ok;

    assign wr_ok = config_i.valid && !cfg_lock_i;

    // ----------------------------------------
    // Loaded flags
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            loaded_q <= 3'b000;
        end else if (wr_ok) begin
            case (config_i.field)
                CFG_OPCODE: loaded_q[0] <= 1'b1;
                CFG_VALUE:  loaded_q[1] <= 1'b1;
                CFG_COUNT:  loaded_q[2] <= 1'b1;
                default:    loaded_q    <= loaded_q;
            endcase
        end
    end

    // ----------------------------------------
    // Field registers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            case (config_i.field)
                CFG_OPCODE: cfg_q.op    <= filter_op_e'(config_i.word[2:0]);
                CFG_VALUE:  cfg_q.value <= config_i.word;
                CFG_COUNT:  cfg_q.count <= config_i.word[COUNT_W-1:0];
                default:    cfg_q       <= cfg_q;
            endcase
        end
    end

    assign cfg_o        = cfg_q;
    assign cfg_loaded_o = &loaded_q;

endmodule : filter_cond_config

// ==== logic/filter_cond_generator.sv ====
/*
 * Filter-condition generator
 * Run FSM plus a two-stage pipeline. Stage one pops the input FIFO,
 * stage two compares the returned word against the configured value
 * and pushes passing packets. Finishes after the configured count.
 */

`timescale 1ns/1ps

module filter_cond_generator
    import filter_cond_pkg::*;
(
    input  logic        ap_clk,
    input  logic        areset_csr_engine,
    input  descriptor_t descriptor_i,
    input  filter_cfg_t cfg_i,
    input  logic        cfg_loaded_i,
    output logic        cfg_lock_o,
    output logic        pop_o,
    input  pkt_t        pkt_i,
    input  logic        out_full_i,
    output pkt_t        pkt_o,
    output logic        done_o
);

    gen_state_e         state;
    gen_state_e         state_next;
    logic [COUNT_W-1:0] consumed_cnt;
    logic [COUNT_W:0]   issued_cnt;
    logic               pop_pending;
    logic               pop_int;
    logic               start;
    logic               run_done;

    // Unsigned compare of a data word against the configured value
    function automatic logic compare_pass(
        input filter_op_e        op,
        input logic [DATA_W-1:0] data,
        input logic [DATA_W-1:0] value
    );
        logic pass;
        case (op)
            OP_EQ:   pass = (data == value);
            OP_NE:   pass = (data != value);
            OP_LT:   pass = (data < value);
            OP_GT:   pass = (data > value);
            OP_LE:   pass = (data <= value);
            OP_GE:   pass = (data >= value);
            default: pass = 1'b0;
        endcase
        return pass;
    endfunction

    // ----------------------------------------
    // Run control
    // ----------------------------------------
    assign start = descriptor_i.valid && ((state == ST_IDLE) || (state == ST_DONE));

    // A pop from last cycle may still return a word, so count it as issued
    assign issued_cnt = {1'b0, consumed_cnt} + (COUNT_W + 1)'(pop_pending);
    assign pop_int    = (state == ST_RUN) && (issued_cnt < {1'b0, cfg_i.count})
                        && !out_full_i;
    assign run_done   = (state == ST_RUN) && (consumed_cnt == cfg_i.count);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:     if (start) state_next = ST_WAIT_CFG;
            ST_WAIT_CFG: if (cfg_loaded_i) state_next = ST_RUN;
            ST_RUN:      if (run_done) state_next = ST_DONE;
            ST_DONE:     state_next = start ? ST_WAIT_CFG : ST_IDLE;
            default:     state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state        <= ST_IDLE;
            consumed_cnt <= '0;
            pop_pending  <= 1'b0;
        end else begin
            state       <= state_next;
            pop_pending <= pop_int;
            if (start) begin
                consumed_cnt <= '0;
            end else if (pop_pending && pkt_i.valid) begin
                consumed_cnt <= consumed_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Compare and push stage
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        pkt_o.id   <= pkt_i.id;
        pkt_o.data <= pkt_i.data;
        if (areset_csr_engine) begin
            pkt_o.valid <= 1'b0;
        end else begin
            pkt_o.valid <= pkt_i.valid && compare_pass(cfg_i.op, pkt_i.data, cfg_i.value);
        end
    end

    assign pop_o      = pop_int;
    assign cfg_lock_o = (state == ST_RUN);
    // Falls in the same cycle the start pulse is seen
    assign done_o     = !start && ((state == ST_IDLE) || (state == ST_DONE));

endmodule : filter_cond_generator

// ==== logic/filter_cond_pkg.sv ====
/*
 * Filter-condition engine shared definitions
 * Widths, packet and configuration structs, opcode and state encodings
 * used by the FIFOs, the configuration block and the generator
 */

package filter_cond_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    parameter int DATA_W  = 32;
    parameter int ID_W    = 8;
    parameter int COUNT_W = 16;

    // ----------------------------------------
    // Encodings
    // ----------------------------------------
    typedef enum logic [2:0] {
        OP_EQ = 3'd0,
        OP_NE = 3'd1,
        OP_LT = 3'd2,
        OP_GT = 3'd3,
        OP_LE = 3'd4,
        OP_GE = 3'd5
    } filter_op_e;

    typedef enum logic [1:0] {
        CFG_OPCODE = 2'd0,
        CFG_VALUE  = 2'd1,
        CFG_COUNT  = 2'd2
    } cfg_field_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_WAIT_CFG = 2'd1,
        ST_RUN      = 2'd2,
        ST_DONE     = 2'd3
    } gen_state_e;

    // ----------------------------------------
    // Packets
    // ----------------------------------------
    // Graph data word with its tag
    typedef struct packed {
        logic              valid;
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
    } pkt_t;

    // Opcode sits in the low bits of word, count in the low COUNT_W bits
    typedef struct packed {
        logic              valid;
        cfg_field_e        field;
        logic [DATA_W-1:0] word;
    } cfg_pkt_t;

    typedef struct packed {
        filter_op_e         op;
        logic [DATA_W-1:0]  value;
        logic [COUNT_W-1:0] count;
    } filter_cfg_t;

    typedef struct packed {
        logic        valid;
        logic [15:0] run_tag;
    } descriptor_t;

endpackage : filter_cond_pkg

// ==== logic/sync_fifo.sv ====
/*
 * Synchronous FIFO
 * Circular buffer with an occupancy counter. A pop returns its word one
 * cycle later, marked by a one-cycle valid strobe. Programmable-full is
 * high while the occupancy is at or above PROG_THRESH.
 */

`timescale 1ns/1ps

module sync_fifo #(
    parameter int DATA_W_P    = 40,
    parameter int FIFO_DEPTH  = 16,
    parameter int PROG_THRESH = 8
) (
    input  logic                ap_clk,
    input  logic                areset_csr_engine,
    input  logic                push_i,
    input  logic [DATA_W_P-1:0] din_i,
    input  logic                pop_i,
    output logic [DATA_W_P-1:0] dout_o,
    output logic                valid_o,
    output logic                empty_o,
    output logic                prog_full_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DATA_W_P-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                push_ok;
    logic                pop_ok;

    // Requests on a full or empty FIFO are dropped
    assign push_ok = push_i && (count != CNT_W'(FIFO_DEPTH));
    assign pop_ok  = pop_i && (count != '0);

    assign empty_o     = (count == '0);
    assign prog_full_o = (count >= CNT_W'(PROG_THRESH));

    // ----------------------------------------
    // Pointers and occupancy
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= pop_ok;
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ----------------------------------------
    // Storage and read data
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din_i;
        end
        if (pop_ok) begin
            dout_o <= mem[rd_ptr];
        end
    end

endmodule : sync_fifo

// ==== run_sim.sh ====
#!/bin/sh
# Build the filter-condition engine testbench with Verilator, run it and grade the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_engine_filter_cond -o tb_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "^Testbench passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== sim/filter_cond_properties.sv ====
/*
 * Filter-condition engine assertions
 * Reset, input FIFO overflow, configuration lock and done checks,
 * bound into the top level
 */

`timescale 1ns/1ps

module filter_cond_properties
    import filter_cond_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input logic                            ap_clk,
    input logic                            areset_local_i,
    input logic                            request_valid_i,
    input logic                            resp_push_i,
    input logic [$clog2(FIFO_DEPTH+1)-1:0] resp_count_i,
    input logic                            cfg_lock_i,
    input filter_cfg_t                     cfg_i,
    input gen_state_e                      gen_state_i,
    input logic                            done_i
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    a_reset_request: assert property (@(posedge ap_clk) areset_local_i |=> !request_valid_i)
        else $error("request_o valid high during reset");

    // Push into a full input FIFO would lose a packet
    a_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_local_i)
        resp_push_i |-> (resp_count_i != CNT_W'(FIFO_DEPTH)))
        else $error("push into a full response FIFO");

    a_cfg_locked: assert property (@(posedge ap_clk) disable iff (areset_local_i)
        cfg_lock_i |=> $stable(cfg_i))
        else $error("configuration changed while locked");

    a_done_run: assert property (@(posedge ap_clk) disable iff (areset_local_i)
        (gen_state_i == ST_RUN) |-> !done_i)
        else $error("done_o high while the generator runs");

endmodule : filter_cond_properties

bind engine_filter_cond filter_cond_properties #(
    .FIFO_DEPTH(FIFO_DEPTH)
) u_properties (
    .ap_clk         (ap_clk),
    .areset_local_i (areset_local),
    .request_valid_i(request_o.valid),
    .resp_push_i    (response_reg.valid),
    .resp_count_i   (u_fifo_response.count),
    .cfg_lock_i     (cfg_lock),
    .cfg_i          (cfg),
    .gen_state_i    (u_generator.state),
    .done_i         (done_o)
);

// ==== sim/tb_engine_filter_cond.sv ====
/*
 * Filter-condition engine testbench
 * Applies a table of filter runs to the engine, streams random response
 * packets under back-pressure and checks request_o against a reference
 * model of the unsigned compare rule
 */

`timescale 1ns/1ps

module tb_engine_filter_cond
    import filter_cond_pkg::*;
();

    localparam int NUM_ROWS       = 9;
    localparam int MAX_PKTS       = 256;
    localparam int RAND_READY_ROW = 7;
    localparam int PKT_W          = ID_W + DATA_W;

    typedef struct packed {
        filter_op_e         op;
        logic [DATA_W-1:0]  value;
        logic [COUNT_W-1:0] count;
        logic               mid_write;
    } row_t;

    logic        ap_clk = 1'b0;
    logic        areset_csr_engine;
    pkt_t        response_i = '0;
    logic        response_ready_o;
    cfg_pkt_t    config_i;
    descriptor_t descriptor_i;
    pkt_t        request_o;
    logic        request_ready_i = 1'b1;
    logic        done_o;

    row_t             rows [NUM_ROWS];
    logic [PKT_W-1:0] stream [MAX_PKTS];
    logic [PKT_W-1:0] expected_q [$];
    filter_cfg_t      model_cfg;
    logic             model_loaded = 1'b0;
    integer           seed;
    logic [31:0]      ready_rnd;
    int               total_pkts = 0;
    int               send_idx = 0;
    logic             send_en = 1'b0;
    logic             ready_seen = 1'b0;
    logic             rand_ready = 1'b0;
    int               errors = 0;
    int               checks = 0;
    int               cycle_cnt = 0;
    int               timeout_limit = 0;

    engine_filter_cond #(
        .FIFO_DEPTH (16),
        .PROG_THRESH(8)
    ) u_engine_filter_cond (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .response_i       (response_i),
        .response_ready_o (response_ready_o),
        .config_i         (config_i),
        .descriptor_i     (descriptor_i),
        .request_o        (request_o),
        .request_ready_i  (request_ready_i),
        .done_o           (done_o)
    );

    always #10 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Reference rule and helpers
    // ----------------------------------------
    function automatic logic passes_rule(input filter_op_e op, input logic [DATA_W-1:0] data,
                                         input logic [DATA_W-1:0] value);
        case (op)
            OP_EQ:   return data == value;
            OP_NE:   return data != value;
            OP_LT:   return data < value;
            OP_GT:   return data > value;
            OP_LE:   return data <= value;
            OP_GE:   return data >= value;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    task automatic write_config(input cfg_field_e sel, input logic [DATA_W-1:0] word);
        @(posedge ap_clk);
        config_i <= '{valid: 1'b1, field: sel, word: word};
        @(posedge ap_clk);
        config_i <= '0;
    endtask

    // Random words, every fourth one equal to the row's value
    task automatic build_stimulus();
        logic [DATA_W-1:0] data;
        int                idx;
        idx = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int j = 0; j < int'(rows[r].count); j++) begin
                data = $random(seed);
                if (j % 4 == 3) begin
                    data = rows[r].value;
                end
                stream[idx] = {8'(idx), data};
                if (passes_rule(rows[r].op, data, rows[r].value)) begin
                    expected_q.push_back(stream[idx]);
                end
                idx++;
            end
        end
        total_pkts = idx;
    endtask

    // Unchanged fields are not rewritten, so the permanent config is reused
    task automatic run_row(input int r);
        row_t row;
        row = rows[r];
        rand_ready = (r >= RAND_READY_ROW);
        if (!model_loaded || row.op != model_cfg.op) begin
            write_config(CFG_OPCODE, 32'(row.op));
        end
        if (!model_loaded || row.value != model_cfg.value) begin
            write_config(CFG_VALUE, row.value);
        end
        if (!model_loaded || row.count != model_cfg.count) begin
            write_config(CFG_COUNT, 32'(row.count));
        end
        model_cfg    = '{op: row.op, value: row.value, count: row.count};
        model_loaded = 1'b1;
        @(posedge ap_clk);
        descriptor_i <= '{valid: 1'b1, run_tag: 16'(r)};
        @(posedge ap_clk);
        descriptor_i.valid <= 1'b0;
        @(posedge ap_clk);
        @(negedge ap_clk);
        check_value("done_o", 64'(done_o), 64'(0));
        // Locked write, expected to be dropped
        if (row.mid_write) begin
            repeat (4) @(posedge ap_clk);
            write_config(CFG_VALUE, row.value ^ 32'h5a5a_5a5a);
        end
        while (done_o !== 1'b1) begin
            @(negedge ap_clk);
        end
    endtask

    // ----------------------------------------
    // Sender, ready driver, monitor, timeout
    // ----------------------------------------
    always @(negedge ap_clk) begin
        ready_seen <= response_ready_o;
    end

    always @(posedge ap_clk) begin
        if (send_en && ready_seen && send_idx < total_pkts) begin
            response_i <= '{valid: 1'b1, id: stream[send_idx][PKT_W-1:DATA_W],
                            data: stream[send_idx][DATA_W-1:0]};
            send_idx++;
        end else begin
            response_i <= '0;
        end
    end

    always @(posedge ap_clk) begin
        if (rand_ready) begin
            ready_rnd = $random(seed);
            request_ready_i <= (ready_rnd[1:0] == 2'b00);
        end else begin
            request_ready_i <= 1'b1;
        end
    end

    always @(negedge ap_clk) begin
        if (!areset_csr_engine && request_o.valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                errors++;
                $display("request_o sent packet 0x%0h when no packet was expected",
                         {request_o.id, request_o.data});
            end else begin
                check_value("request_o", 64'({request_o.id, request_o.data}),
                            64'(expected_q.pop_front()));
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_cnt++;
        if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        seed              = 32'hb7a19dbc;
        areset_csr_engine = 1'b1;
        config_i          = '0;
        descriptor_i      = '0;
        rows[0] = '{op: OP_EQ, value: 32'h8000_0000, count: 16'd12, mid_write: 1'b0};
        rows[1] = '{op: OP_NE, value: 32'h8000_0000, count: 16'd12, mid_write: 1'b0};
        rows[2] = '{op: OP_LT, value: 32'h4000_0000, count: 16'd16, mid_write: 1'b0};
        rows[3] = '{op: OP_GT, value: 32'h4000_0000, count: 16'd16, mid_write: 1'b1};
        rows[4] = '{op: OP_LE, value: 32'h4000_0000, count: 16'd20, mid_write: 1'b0};
        rows[5] = '{op: OP_GE, value: 32'hc000_0000, count: 16'd20, mid_write: 1'b0};
        rows[6] = '{op: OP_EQ, value: 32'hc000_0000, count: 16'd0,  mid_write: 1'b0};
        rows[7] = '{op: OP_GE, value: 32'h8000_0000, count: 16'd24, mid_write: 1'b1};
        rows[8] = '{op: OP_LT, value: 32'h8000_0000, count: 16'd24, mid_write: 1'b0};
        build_stimulus();
        timeout_limit = total_pkts * 40 + 2000;

        repeat (10) @(posedge ap_clk);
        areset_csr_engine <= 1'b0;
        repeat (3) @(negedge ap_clk);
        check_value("done_o", 64'(done_o), 64'(1));
        check_value("request_o.valid", 64'(request_o.valid), 64'(0));
        check_value("response_ready_o", 64'(response_ready_o), 64'(1));

        send_en = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        while (expected_q.size() != 0) begin
            @(negedge ap_clk);
        end
        // Catch late or duplicated outputs
        repeat (40) @(negedge ap_clk);
        // Every packet consumed, so the input FIFO has drained
        check_value("response_ready_o", 64'(response_ready_o), 64'(1));
        check_value("done_o", 64'(done_o), 64'(1));

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_engine_filter_cond
